// File: src/id_pkg.sv
package id_pkg;

	// Widths that carry a meaning in the decode stage
	typedef logic [31:0] inst_t;
	typedef logic [31:0] data_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [6:0]  opcode_t;

	// Operation class handed to the later stages
	// illegal covers unknown opcodes and bad low bits
	typedef enum logic [3:0] {
		lui,
		auipc,
		jal,
		jalr,
		branch,
		load,
		store,
		op_imm,
		op,
		fence,
		system,
		illegal
	} op_class_e;

	// RV32I base opcodes, instruction bits 6:0
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_FENCE  = 7'b0001111;
	localparam opcode_t OPC_SYSTEM = 7'b1110011;

	// Fetched instruction with its PC
	typedef struct packed {
		data_t pc;
		inst_t inst;
	} fetch_pkt_t;

	// Decoded packet sent downstream
	typedef struct packed {
		data_t     pc;
		op_class_e op_class;
		reg_idx_t  rd;
		reg_idx_t  rs1;
		reg_idx_t  rs2;
		logic [2:0] funct3;
		logic      rd_we;
		logic      rs1_used;
		logic      rs2_used;
		data_t     imm;
	} dec_pkt_t;

endpackage

// File: src/id_imm_gen.sv
`timescale 1ns/1ns

module id_imm_gen (
	input  id_pkg::inst_t inst,
	output id_pkg::data_t imm
);
	import id_pkg::*;

	opcode_t opcode;

	// One candidate per format
	data_t imm_i;
	data_t imm_s;
	data_t imm_b;
	data_t imm_u;
	data_t imm_j;

	assign opcode = inst[6:0];

	// Sign always comes from bit 31
	// I format, 12 bits
	assign imm_i = {{21{inst[31]}}, inst[30:20]};

	// S format, upper and lower halves split around rs2
	assign imm_s = {{21{inst[31]}}, inst[30:25], inst[11:7]};

	// B format, halfword offset so bit 0 is zero
	assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

	// U format fills the upper 20 bits
	assign imm_u = {inst[31:12], 12'b0};

	// J format, 21 bit offset scrambled across the word
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	// Format select
	always_comb begin
		case (opcode)
			OPC_LUI,
			OPC_AUIPC:  imm = imm_u;
			OPC_JAL:    imm = imm_j;
			OPC_BRANCH: imm = imm_b;
			OPC_STORE:  imm = imm_s;
			// SYSTEM gets the I immediate only, CSR fields are not split out
			OPC_JALR,
			OPC_LOAD,
			OPC_OP_IMM,
			OPC_SYSTEM: imm = imm_i;
			// R type, FENCE and unknown opcodes carry no immediate
			default:    imm = '0;
		endcase
	end

endmodule

// File: src/id_decoder.sv
`timescale 1ns/1ns

module id_decoder (
	input  id_pkg::fetch_pkt_t q_pkt,
	output id_pkg::dec_pkt_t   dec_pkt
);
	import id_pkg::*;

	opcode_t   opcode;
	op_class_e op_class;
	// Raw immediate before the illegal override
	data_t     imm;

	assign opcode = q_pkt.inst[6:0];

	id_imm_gen u_imm_gen (
		.inst (q_pkt.inst),
		.imm  (imm)
	);

	// Opcode to class
	always_comb begin
		case (opcode)
			OPC_LUI:    op_class = lui;
			OPC_AUIPC:  op_class = auipc;
			OPC_JAL:    op_class = jal;
			OPC_JALR:   op_class = jalr;
			OPC_BRANCH: op_class = branch;
			OPC_LOAD:   op_class = load;
			OPC_STORE:  op_class = store;
			OPC_OP_IMM: op_class = op_imm;
			OPC_OP:     op_class = op;
			OPC_FENCE:  op_class = fence;
			OPC_SYSTEM: op_class = system;
			default:    op_class = illegal;
		endcase
		// Compressed encodings are not supported
		if (q_pkt.inst[1:0] != 2'b11) begin
			op_class = illegal;
		end
	end

	always_comb begin
		dec_pkt.pc       = q_pkt.pc;
		dec_pkt.op_class = op_class;
		// Register fields sit at fixed positions in every format
		dec_pkt.rd       = q_pkt.inst[11:7];
		dec_pkt.rs1      = q_pkt.inst[19:15];
		dec_pkt.rs2      = q_pkt.inst[24:20];
		dec_pkt.funct3   = q_pkt.inst[14:12];
		// Flags stay clear for illegal since it is in none of the sets
		dec_pkt.rd_we    = op_class inside {lui, auipc, jal, jalr, load, op_imm, op};
		dec_pkt.rs1_used = op_class inside {jalr, branch, load, store, op_imm, op};
		dec_pkt.rs2_used = op_class inside {branch, store, op};
		// Bad low bits can still hit a known opcode in the immediate generator
		dec_pkt.imm      = (op_class == illegal) ? '0 : imm;
	end

endmodule

// File: src/id_fetch_queue.sv
`timescale 1ns/1ns

module id_fetch_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  id_pkg::fetch_pkt_t in_pkt,
	output logic               in_credit,
	output logic               q_valid,
	output id_pkg::fetch_pkt_t q_pkt,
	input  logic               pop
);
	import id_pkg::*;

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	// Entry storage, payload only
	fetch_pkt_t mem [QUEUE_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	// Occupancy, 0 to QUEUE_DEPTH
	logic [CNT_W-1:0] count;

	// Head is visible as soon as the count is nonzero
	assign q_valid = (count != '0);
	assign q_pkt   = mem[rd_ptr];

	// Credit goes back upstream in the pop cycle itself
	assign in_credit = pop;

	// Upstream never sends without a credit, so no full check here
	always_ff @(posedge clk) begin
		if (in_valid) begin
			mem[wr_ptr] <= in_pkt;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Pointers wrap at QUEUE_DEPTH, depth need not be a power of two
			if (in_valid) begin
				wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Write and pop together leave the count alone
			case ({in_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: src/id_out_stage.sv
`timescale 1ns/1ns

module id_out_stage #(
	parameter int OUT_CREDITS = 2
) (
	input  logic             clk,
	input  logic             rst_n,
	input  id_pkg::dec_pkt_t dec_pkt,
	input  logic             q_valid,
	output logic             pop,
	output logic             out_valid,
	output id_pkg::dec_pkt_t out_pkt,
	input  logic             out_credit
);

	localparam int CNT_W = $clog2(OUT_CREDITS + 1);

	// Downstream credits in hand
	logic [CNT_W-1:0] credit_cnt;
	logic             has_credit;

	// A credit arriving this cycle can be spent right away
	assign has_credit = (credit_cnt != '0) || out_credit;

	// Take the head only when it can be sent
	assign pop = q_valid && has_credit;

	// Count may go up and down in the same cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credit_cnt <= CNT_W'(OUT_CREDITS);
		end else begin
			credit_cnt <= credit_cnt + CNT_W'(out_credit) - CNT_W'(pop);
		end
	end

	// One cycle valid per packet sent
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= pop;
		end
	end

	// Packet register, only loaded on a send
	always_ff @(posedge clk) begin
		if (pop) begin
			out_pkt <= dec_pkt;
		end
	end

endmodule

// File: src/id_stage_top.sv
`timescale 1ns/1ns

module id_stage_top #(
	parameter int QUEUE_DEPTH = 4,
	parameter int OUT_CREDITS = 2
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  id_pkg::fetch_pkt_t in_pkt,
	output logic               in_credit,
	output logic               out_valid,
	output id_pkg::dec_pkt_t   out_pkt,
	input  logic               out_credit
);
	import id_pkg::*;

	// Queue head
	logic       q_valid;
	fetch_pkt_t q_pkt;
	// Head taken by the output stage
	logic       pop;
	// Combinational decode of the head
	dec_pkt_t   dec_pkt;

	id_fetch_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_fetch_queue (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_pkt    (in_pkt),
		.in_credit (in_credit),
		.q_valid   (q_valid),
		.q_pkt     (q_pkt),
		.pop       (pop)
	);

	id_decoder u_decoder (
		.q_pkt   (q_pkt),
		.dec_pkt (dec_pkt)
	);

	id_out_stage #(
		.OUT_CREDITS (OUT_CREDITS)
	) u_out_stage (
		.clk        (clk),
		.rst_n      (rst_n),
		.dec_pkt    (dec_pkt),
		.q_valid    (q_valid),
		.pop        (pop),
		.out_valid  (out_valid),
		.out_pkt    (out_pkt),
		.out_credit (out_credit)
	);

endmodule

// File: verif/id_stage_chk.sv
`timescale 1ns/1ns

module id_stage_chk #(
	parameter int QUEUE_DEPTH = 4,
	parameter int OUT_CREDITS = 2
) (
	input logic                             clk,
	input logic                             rst_n,
	input logic                             out_valid,
	input logic                             out_credit,
	input logic                             in_valid,
	input logic                             in_credit,
	input logic [$clog2(OUT_CREDITS+1)-1:0] credit_cnt,
	input logic [$clog2(QUEUE_DEPTH+1)-1:0] q_count
);

	// Failures seen so far, read by the testbench at the end
	int fail_cnt = 0;

	// Counters rebuilt from the ports alone
	// Packets written upstream and not yet credited back
	int occ_seen;
	// Downstream credits left, spent when out_valid shows up
	int credits_seen;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			occ_seen     <= 0;
			credits_seen <= OUT_CREDITS;
		end else begin
			occ_seen     <= occ_seen + int'(in_valid) - int'(in_credit);
			credits_seen <= credits_seen + int'(out_credit) - int'(out_valid);
		end
	end

	// out_valid trails its pop by one edge, so a credit back in the pop cycle counts
	a_send_credit: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> credits_seen > 0)
		else begin
			$error("out_valid without a downstream credit");
			fail_cnt++;
		end

	a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
		credit_cnt <= OUT_CREDITS)
		else begin
			$error("downstream credit count above its initial value");
			fail_cnt++;
		end

	// Upstream holds no credit while the queue is full
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> q_count < QUEUE_DEPTH)
		else begin
			$error("queue written while full");
			fail_cnt++;
		end

	// A credit goes back only for a packet written earlier and still held
	a_credit_nonempty: assert property (@(posedge clk) disable iff (!rst_n)
		in_credit |-> occ_seen > 0)
		else begin
			$error("in_credit pulsed with an empty queue");
			fail_cnt++;
		end

endmodule

// Reaches into the output stage and the queue from the top level
bind id_stage_top id_stage_chk #(
	.QUEUE_DEPTH (QUEUE_DEPTH),
	.OUT_CREDITS (OUT_CREDITS)
) u_chk (
	.clk        (clk),
	.rst_n      (rst_n),
	.out_valid  (out_valid),
	.out_credit (out_credit),
	.in_valid   (in_valid),
	.in_credit  (in_credit),
	.credit_cnt (u_out_stage.credit_cnt),
	.q_count    (u_fetch_queue.count)
);

// File: verif/tb_id_stage.sv
`timescale 1ns/1ns

module tb_id_stage;
	import id_pkg::*;

	localparam int QUEUE_DEPTH = 4;
	localparam int OUT_CREDITS = 2;
	localparam int NUM_RANDOM  = 300;
	localparam int WAIT_LIMIT  = 2000;
	localparam logic [31:0] SEED = 32'd38022;

	logic       clk;
	logic       rst_n;
	logic       in_valid;
	fetch_pkt_t in_pkt;
	logic       in_credit;
	logic       out_valid;
	dec_pkt_t   out_pkt;
	logic       out_credit;

	// Expected packets in send order
	dec_pkt_t    exp_q[$];
	logic [31:0] rng_up;
	logic [31:0] rng_dn;
	int          up_credits;
	// Credits the downstream model still owes the DUT
	int          owed;
	int          sent;
	int          received;
	int          credit_pulses;
	int          errors;
	int          timeouts;
	// Downstream schedule, release_en gates returns and dn_slow spaces them out
	logic        release_en;
	int          dn_slow;

	opcode_t legal_opc [11] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
		OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_FENCE, OPC_SYSTEM};

	id_stage_top #(
		.QUEUE_DEPTH (QUEUE_DEPTH),
		.OUT_CREDITS (OUT_CREDITS)
	) u_id_stage_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_pkt     (in_pkt),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_pkt    (out_pkt),
		.out_credit (out_credit)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_up();
		rng_up = xorshift(rng_up);
		return rng_up;
	endfunction

	// Random word with the opcode forced, PC word aligned
	function automatic fetch_pkt_t make_pkt(input opcode_t opc);
		fetch_pkt_t p;
		p.inst      = next_up();
		p.inst[6:0] = opc;
		p.pc        = next_up() & 32'hffff_fffc;
		return p;
	endfunction

	// Mostly legal, some unknown opcodes and some with low bits 10
	function automatic opcode_t rand_opcode();
		int r;
		r = int'(next_up() % 14);
		if (r < 11)
			return legal_opc[r];
		if (r == 11)
			return 7'b1111111;
		if (r == 12)
			return 7'b0101011;
		return legal_opc[next_up() % 11] ^ 7'b0000001;
	endfunction

	// Expected decode, straight from the RV32I encoding tables
	function automatic dec_pkt_t ref_decode(input fetch_pkt_t f);
		dec_pkt_t d;
		inst_t    i;
		i        = f.inst;
		d        = '0;
		d.pc     = f.pc;
		d.rd     = i[11:7];
		d.rs1    = i[19:15];
		d.rs2    = i[24:20];
		d.funct3 = i[14:12];
		if (i[1:0] != 2'b11) begin
			d.op_class = illegal;
		end else begin
			case (i[6:0])
				OPC_LUI:    d.op_class = lui;
				OPC_AUIPC:  d.op_class = auipc;
				OPC_JAL:    d.op_class = jal;
				OPC_JALR:   d.op_class = jalr;
				OPC_BRANCH: d.op_class = branch;
				OPC_LOAD:   d.op_class = load;
				OPC_STORE:  d.op_class = store;
				OPC_OP_IMM: d.op_class = op_imm;
				OPC_OP:     d.op_class = op;
				OPC_FENCE:  d.op_class = fence;
				OPC_SYSTEM: d.op_class = system;
				default:    d.op_class = illegal;
			endcase
		end
		case (d.op_class)
			lui, auipc:                 d.imm = {i[31:12], 12'h000};
			jal:    d.imm = {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
			branch: d.imm = {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
			store:                      d.imm = {{20{i[31]}}, i[31:25], i[11:7]};
			jalr, load, op_imm, system: d.imm = {{20{i[31]}}, i[31:20]};
			default:                    d.imm = '0;
		endcase
		// Register use per class, rd_we, rs1_used, rs2_used
		case (d.op_class)
			lui, auipc, jal:    {d.rd_we, d.rs1_used, d.rs2_used} = 3'b100;
			jalr, load, op_imm: {d.rd_we, d.rs1_used, d.rs2_used} = 3'b110;
			op:                 {d.rd_we, d.rs1_used, d.rs2_used} = 3'b111;
			branch, store:      {d.rd_we, d.rs1_used, d.rs2_used} = 3'b011;
			default:            {d.rd_we, d.rs1_used, d.rs2_used} = 3'b000;
		endcase
		return d;
	endfunction

	task automatic check_field(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("Error at %0t: out_pkt.%s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_pkt(input dec_pkt_t got, input dec_pkt_t exp);
		check_field("pc", got.pc, exp.pc);
		check_field("op_class", 32'(got.op_class), 32'(exp.op_class));
		check_field("rd", 32'(got.rd), 32'(exp.rd));
		check_field("rs1", 32'(got.rs1), 32'(exp.rs1));
		check_field("rs2", 32'(got.rs2), 32'(exp.rs2));
		check_field("funct3", 32'(got.funct3), 32'(exp.funct3));
		check_field("rd_we", 32'(got.rd_we), 32'(exp.rd_we));
		check_field("rs1_used", 32'(got.rs1_used), 32'(exp.rs1_used));
		check_field("rs2_used", 32'(got.rs2_used), 32'(exp.rs2_used));
		check_field("imm", got.imm, exp.imm);
	endtask

	// Upstream model, idle for gap cycles then send once a credit is held
	task automatic send_pkt(input fetch_pkt_t p, input int gap);
		int waited;
		waited = 0;
		repeat (gap) begin
			@(negedge clk);
			in_valid = 1'b0;
		end
		@(negedge clk);
		in_valid = 1'b0;
		while (up_credits == 0 && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (up_credits == 0) begin
			timeouts++;
			$display("Timeout at %0t: no upstream credit came back", $time);
		end else begin
			in_valid = 1'b1;
			in_pkt   = p;
			exp_q.push_back(ref_decode(p));
			sent++;
		end
	endtask

	task automatic idle_in();
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	// All sent packets out and all downstream credits handed back
	task automatic wait_drain();
		int waited;
		waited = 0;
		while ((received != sent || owed != 0) && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (received != sent || owed != 0) begin
			timeouts++;
			$display("Timeout at %0t: %0d of %0d packets came out", $time, received, sent);
		end
	endtask

	// Downstream model returns one credit per cycle at most
	always @(negedge clk) begin
		rng_dn     = xorshift(rng_dn);
		out_credit = release_en && (owed > 0) && (rng_dn % (dn_slow + 1) == 0);
	end

	// Credit bookkeeping and the compare, on values from just before the edge
	always @(posedge clk) begin : monitor
		dec_pkt_t exp;
		if (rst_n) begin
			up_credits    = up_credits + in_credit - in_valid;
			owed          = owed + out_valid - out_credit;
			credit_pulses = credit_pulses + in_credit;
			assert (sent <= received + QUEUE_DEPTH + OUT_CREDITS) else begin
				errors++;
				$display("Sent count %0d runs too far ahead of received %0d", sent, received);
			end
			if (out_valid) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("out_valid at %0t with no packet outstanding", $time);
				end else begin
					exp = exp_q.pop_front();
					compare_pkt(out_pkt, exp);
				end
				received++;
			end
		end
	end

	initial begin : stimulus
		fetch_pkt_t p;
		int gap;
		int base;
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_pkt     = '0;
		out_credit = 1'b0;
		release_en = 1'b1;
		dn_slow    = 0;
		up_credits = QUEUE_DEPTH;
		owed       = 0;
		{sent, received, credit_pulses, errors, timeouts} = '0;
		rng_up     = SEED;
		rng_dn     = SEED ^ 32'h9e37_79b9;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Quiet outputs before any input
		repeat (10) begin
			@(posedge clk);
			assert (out_valid === 1'b0 && in_credit === 1'b0) else begin
				errors++;
				$display("Error at %0t: out_valid is %b, in_credit is %b, expected 0",
					$time, out_valid, in_credit);
			end
		end

		// Every format with bit 31 clear and set
		foreach (legal_opc[k]) begin
			p = make_pkt(legal_opc[k]);
			p.inst[31] = 1'b0;
			send_pkt(p, 0);
			p = make_pkt(legal_opc[k]);
			p.inst[31] = 1'b1;
			send_pkt(p, 1);
		end
		// Bad low bits on known opcodes, then unknown opcodes
		foreach (legal_opc[k]) begin
			p = make_pkt(legal_opc[k]);
			p.inst[1:0] = 2'(k % 3);
			send_pkt(p, 0);
		end
		send_pkt(make_pkt(7'b1111111), 0);
		send_pkt(make_pkt(7'b0101011), 0);
		idle_in();
		wait_drain();

		// Random stream with prompt credit returns
		repeat (NUM_RANDOM) begin
			p   = make_pkt(rand_opcode());
			gap = int'(next_up() % 3);
			send_pkt(p, gap);
		end
		idle_in();
		wait_drain();

		// Back-pressure, fill the output credits and the queue
		release_en = 1'b0;
		base       = received;
		repeat (QUEUE_DEPTH + OUT_CREDITS) begin
			p = make_pkt(rand_opcode());
			send_pkt(p, 0);
		end
		idle_in();
		// Observation window, nothing more may come out
		repeat (20) @(negedge clk);
		assert (received - base == OUT_CREDITS) else begin
			errors++;
			$display("%0d packets came out with credits withheld", received - base);
		end
		assert (up_credits == 0) else begin
			errors++;
			$display("Upstream still holds %0d credits while stalled", up_credits);
		end
		release_en = 1'b1;
		dn_slow    = 1;
		repeat (20) begin
			p = make_pkt(rand_opcode());
			send_pkt(p, 0);
		end
		idle_in();
		wait_drain();

		assert (credit_pulses == sent) else begin
			errors++;
			$display("%0d in_credit pulses for %0d packets sent", credit_pulses, sent);
		end
		$display("Done: %0d errors, %0d timeouts, %0d assertion failures, %0d packets",
			errors, timeouts, u_id_stage_top.u_chk.fail_cnt, sent);
		if (errors == 0 && timeouts == 0 && u_id_stage_top.u_chk.fail_cnt == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Overall limit on the run
	initial begin
		repeat (200000) @(posedge clk);
		$display("Simulation ran too long and was stopped");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: flist.f
src/id_pkg.sv
src/id_imm_gen.sv
src/id_decoder.sv
src/id_fetch_queue.sv
src/id_out_stage.sv
src/id_stage_top.sv
verif/id_stage_chk.sv
verif/tb_id_stage.sv
